// File: design/chip_io_pkg.sv
// Chip I/O package
// Pad, peripheral and strap sizes shared by the multiplexed I/O block,
// with the vector and select types built from them

package chip_io_pkg;

  // Sizes
  localparam int NumMio       = 16;  // Multiplexed pads
  localparam int NumPeriphOut = 8;
  localparam int NumPeriphIn  = 8;

  // Software straps live on the top pads
  localparam int StrapPadBase = 13;
  localparam int NumStraps    = 3;
  localparam int StrapDelay   = 4;   // Edges after reset release
  localparam int StrapCntW    = $clog2(StrapDelay);

  // Per-pad and per-peripheral vectors
  typedef logic [NumMio-1:0]       mio_t;
  typedef logic [NumPeriphOut-1:0] periph_out_t;
  typedef logic [NumPeriphIn-1:0]  periph_in_t;

  // Select encodings use 0 as "none", k selects source k-1
  typedef logic [3:0] out_sel_t;   // 0 undriven, 1..8 periph out
  typedef logic [4:0] in_sel_t;    // 0 zero, 1..16 pad

  // Indices
  typedef logic [$clog2(NumMio)-1:0]       pad_idx_t;
  typedef logic [$clog2(NumPeriphIn)-1:0]  periph_idx_t;
  typedef logic [$clog2(NumPeriphOut)-1:0] periph_out_idx_t;

  typedef logic [NumStraps-1:0] strap_t;
  typedef logic [StrapCntW-1:0] strap_cnt_t;

endpackage

// File: design/mio_pad.sv
// MIO pad cell
// Registers output data and enable toward the pad and brings the
// pad input into the core clock domain through two flops

`timescale 1ns/1ps

module mio_pad (
  input  logic clk_i,
  input  logic reset_i,
  input  logic out_i,      // From output mux
  input  logic oe_i,
  input  logic pad_i,      // From the outside
  output logic pad_o,
  output logic pad_oe_o,
  output logic in_sync_o   // To input router
);

  logic out_q;
  logic oe_q;
  logic sync_q1;
  logic sync_q2;

  // Output side
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_q <= 1'b0;
      oe_q  <= 1'b0;
    end else begin
      oe_q  <= oe_i;
      out_q <= out_i & oe_i;  // Undriven pad shows zero
    end
  end

  assign pad_o    = out_q;
  assign pad_oe_o = oe_q;

  // Input synchronizer
  always_ff @(posedge clk_i) begin
    sync_q1 <= pad_i;
    sync_q2 <= sync_q1;
  end

  assign in_sync_o = sync_q2;

endmodule

// File: design/mio_out_mux.sv
// MIO output mux
// Keeps one output select per pad and routes the chosen peripheral
// output, with its enable, to every pad cell

`timescale 1ns/1ps

module mio_out_mux (
  input  logic                     clk_i,
  input  logic                     reset_i,
  // Select table write port
  input  logic                     out_sel_we_i,
  input  chip_io_pkg::pad_idx_t    out_sel_pad_i,
  input  chip_io_pkg::out_sel_t    out_sel_i,
  // Peripheral side
  input  chip_io_pkg::periph_out_t periph_out_i,
  // Toward the pad cells
  output chip_io_pkg::mio_t        pad_out_o,
  output chip_io_pkg::mio_t        pad_oe_o
);

  chip_io_pkg::out_sel_t out_sel_q [chip_io_pkg::NumMio];
  logic                  sel_ok;

  // Highest legal select value is the last peripheral output
  assign sel_ok = out_sel_i <= chip_io_pkg::out_sel_t'(chip_io_pkg::NumPeriphOut);

  // Select table
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int k = 0; k < chip_io_pkg::NumMio; k++) begin
        out_sel_q[k] <= '0;  // All pads undriven
      end
    end else if (out_sel_we_i && sel_ok) begin
      out_sel_q[out_sel_pad_i] <= out_sel_i;
    end
  end

  // Per-pad source selection
  for (genvar k = 0; k < chip_io_pkg::NumMio; k++) begin : gen_pad_sel
    chip_io_pkg::periph_out_idx_t src_idx;
    logic                         pad_en;

    // Entry k selects peripheral output k-1
    assign src_idx = chip_io_pkg::periph_out_idx_t'(out_sel_q[k] - 4'd1);
    assign pad_en  = out_sel_q[k] != '0;

    assign pad_oe_o[k]  = pad_en;
    assign pad_out_o[k] = pad_en & periph_out_i[src_idx];
  end

  // A write above the last peripheral is ignored, so the pad keeps
  // whatever routing it had before
  OutSelRange_A: assert property (
    @(posedge clk_i) disable iff (reset_i)
    out_sel_we_i |-> sel_ok
  ) else $warning("mio_out_mux: select %0d for pad %0d dropped",
                  out_sel_i, out_sel_pad_i);

endmodule

// File: design/mio_in_router.sv
// MIO input router
// Per-peripheral pad select table with a registered routing stage, plus
// a one-shot capture of the software strap pads after reset

`timescale 1ns/1ps

module mio_in_router (
  input  logic                     clk_i,
  input  logic                     reset_i,
  // Select table write port
  input  logic                     in_sel_we_i,
  input  chip_io_pkg::periph_idx_t in_sel_periph_i,
  input  chip_io_pkg::in_sel_t     in_sel_i,
  // Synchronized pad inputs
  input  chip_io_pkg::mio_t        pad_in_i,
  // Peripheral side
  output chip_io_pkg::periph_in_t  periph_in_o,
  output chip_io_pkg::strap_t      straps_o,
  output logic                     strap_valid_o
);

  chip_io_pkg::in_sel_t    in_sel_q [chip_io_pkg::NumPeriphIn];
  chip_io_pkg::periph_in_t periph_in_d;
  chip_io_pkg::strap_cnt_t strap_cnt_q;

  // Select table ignores values past the last pad
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < chip_io_pkg::NumPeriphIn; i++) begin
        in_sel_q[i] <= '0;
      end
    end else if (in_sel_we_i &&
                 in_sel_i <= chip_io_pkg::in_sel_t'(chip_io_pkg::NumMio)) begin
      in_sel_q[in_sel_periph_i] <= in_sel_i;
    end
  end

  // Select k picks pad k-1
  always_comb begin
    periph_in_d = '0;
    for (int i = 0; i < chip_io_pkg::NumPeriphIn; i++) begin
      if (in_sel_q[i] != '0) begin
        periph_in_d[i] = pad_in_i[chip_io_pkg::pad_idx_t'(in_sel_q[i] - 5'd1)];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      periph_in_o <= '0;
    end else begin
      periph_in_o <= periph_in_d;
    end
  end

  // Strap sampling
  // Counts edges after reset release and captures once on the last one
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      strap_cnt_q   <= '0;
      straps_o      <= '0;
      strap_valid_o <= 1'b0;
    end else if (!strap_valid_o) begin
      if (strap_cnt_q == chip_io_pkg::strap_cnt_t'(chip_io_pkg::StrapDelay - 1)) begin
        straps_o      <= pad_in_i[chip_io_pkg::StrapPadBase +: chip_io_pkg::NumStraps];
        strap_valid_o <= 1'b1;
      end else begin
        strap_cnt_q <= strap_cnt_q + 1'b1;
      end
    end
  end

  // Captured straps are frozen until the next reset
  StrapsStable_A: assert property (
    @(posedge clk_i) disable iff (reset_i)
    strap_valid_o |=> $stable(straps_o)
  );

  StrapValidHold_A: assert property (
    @(posedge clk_i) disable iff (reset_i)
    strap_valid_o |=> strap_valid_o
  );

endmodule

// File: design/chip_io_top.sv
// Chip I/O top
// Output mux, sixteen pad cells and the input router behind the
// multiplexed pads

`timescale 1ns/1ps

module chip_io_top (
  input  logic                     clk_i,
  input  logic                     reset_i,
  // Output select writes
  input  logic                     out_sel_we_i,
  input  chip_io_pkg::pad_idx_t    out_sel_pad_i,
  input  chip_io_pkg::out_sel_t    out_sel_i,
  // Input select writes
  input  logic                     in_sel_we_i,
  input  chip_io_pkg::periph_idx_t in_sel_periph_i,
  input  chip_io_pkg::in_sel_t     in_sel_i,
  // Peripheral outputs toward the pads
  input  chip_io_pkg::periph_out_t periph_out_i,
  // Pads
  input  chip_io_pkg::mio_t        pad_i,
  output chip_io_pkg::mio_t        pad_o,
  output chip_io_pkg::mio_t        pad_oe_o,
  // Peripheral inputs and straps
  output chip_io_pkg::periph_in_t  periph_in_o,
  output chip_io_pkg::strap_t      straps_o,
  output logic                     strap_valid_o
);

  chip_io_pkg::mio_t mux_out;   // Mux data per pad
  chip_io_pkg::mio_t mux_oe;
  chip_io_pkg::mio_t pad_sync;  // Synchronized pad inputs

  mio_out_mux u_out_mux (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .out_sel_we_i  (out_sel_we_i),
    .out_sel_pad_i (out_sel_pad_i),
    .out_sel_i     (out_sel_i),
    .periph_out_i  (periph_out_i),
    .pad_out_o     (mux_out),
    .pad_oe_o      (mux_oe)
  );

  for (genvar k = 0; k < chip_io_pkg::NumMio; k++) begin : gen_pads
    mio_pad u_pad (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .out_i     (mux_out[k]),
      .oe_i      (mux_oe[k]),
      .pad_i     (pad_i[k]),
      .pad_o     (pad_o[k]),
      .pad_oe_o  (pad_oe_o[k]),
      .in_sync_o (pad_sync[k])
    );
  end

  mio_in_router u_in_router (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .in_sel_we_i     (in_sel_we_i),
    .in_sel_periph_i (in_sel_periph_i),
    .in_sel_i        (in_sel_i),
    .pad_in_i        (pad_sync),
    .periph_in_o     (periph_in_o),
    .straps_o        (straps_o),
    .strap_valid_o   (strap_valid_o)
  );

endmodule

// File: verification/tb_chip_io.sv
// Chip I/O testbench
// Applies a stimulus table to chip_io_top and checks pads, routed inputs
// and straps against a cycle model of the select tables and delay lines

`timescale 1ns/1ps

module tb_chip_io;

  typedef struct packed {
    logic                     out_we;
    chip_io_pkg::pad_idx_t    out_pad;
    chip_io_pkg::out_sel_t    out_sel;
    logic                     in_we;
    chip_io_pkg::periph_idx_t in_per;
    chip_io_pkg::in_sel_t     in_sel;
    chip_io_pkg::periph_out_t periph_out;
    chip_io_pkg::mio_t        pad;
    logic                     rnd_out;  // Random periph_out_i instead
    logic                     rnd_pad;  // Random pad_i instead
    logic                     chk;
  } step_t;

  logic clk_i, reset_i, out_sel_we_i, in_sel_we_i, strap_valid_o;
  chip_io_pkg::pad_idx_t    out_sel_pad_i;
  chip_io_pkg::out_sel_t    out_sel_i;
  chip_io_pkg::periph_idx_t in_sel_periph_i;
  chip_io_pkg::in_sel_t     in_sel_i;
  chip_io_pkg::periph_out_t periph_out_i;
  chip_io_pkg::mio_t        pad_i, pad_o, pad_oe_o;
  chip_io_pkg::periph_in_t  periph_in_o;
  chip_io_pkg::strap_t      straps_o;

  step_t  tbl[$];
  logic   table_built = 1'b0;
  integer seed = 32'h5f45371d;
  int     errors = 0;
  int     checks = 0;

  // Reference model state
  chip_io_pkg::out_sel_t   m_out_sel [chip_io_pkg::NumMio];
  chip_io_pkg::in_sel_t    m_in_sel [chip_io_pkg::NumPeriphIn];
  chip_io_pkg::mio_t       m_sync1, m_sync2;  // Pad input delay line
  chip_io_pkg::mio_t       exp_pad, exp_oe;
  chip_io_pkg::periph_in_t exp_pin;
  chip_io_pkg::strap_t     exp_straps;
  logic                    exp_valid;
  int                      m_strap_cnt;

  chip_io_top dut0 (.*);

  always #2 clk_i = ~clk_i;

  task automatic add_step(input logic ow, input chip_io_pkg::pad_idx_t op,
                          input chip_io_pkg::out_sel_t os, input logic iw,
                          input chip_io_pkg::periph_idx_t ip, input chip_io_pkg::in_sel_t is,
                          input chip_io_pkg::periph_out_t po,
                          input chip_io_pkg::mio_t pad, input logic ro, input logic rp);
    tbl.push_back('{ow, op, os, iw, ip, is, po, pad, ro, rp, 1'b1});
  endtask

  task automatic build_table();
    // Straps 101 held through capture, then the strap pads change
    for (int i = 0; i < 6; i++) add_step(0, 0, 0, 0, 0, 0, 8'hFF, 16'hA000, 0, 0);
    for (int i = 0; i < 3; i++) add_step(0, 0, 0, 0, 0, 0, 8'hFF, 16'h6000, 0, 0);
    // One output select per pad, covering 0 to 8
    for (int k = 0; k < chip_io_pkg::NumMio; k++) begin
      add_step(1, chip_io_pkg::pad_idx_t'(k), chip_io_pkg::out_sel_t'((k * 5) % 9),
               0, 0, 0, 8'h00, 16'h6000, 1, 0);
    end
    for (int i = 0; i < 8; i++) add_step(0, 0, 0, 0, 0, 0, 8'h00, 16'h6000, 1, 0);
    // Pad 3 keeps select 6
    for (int v = 9; v < 16; v++) begin
      add_step(1, 4'd3, chip_io_pkg::out_sel_t'(v), 0, 0, 0, 8'h00, 16'h6000, 1, 0);
    end
    for (int i = 0; i < 4; i++) add_step(0, 0, 0, 0, 0, 0, 8'h00, 16'h6000, 1, 0);
    // Input selects, then two writes past the last pad
    for (int i = 0; i < chip_io_pkg::NumPeriphIn; i++) begin
      add_step(0, 0, 0, 1, chip_io_pkg::periph_idx_t'(i),
               chip_io_pkg::in_sel_t'((i * 7 + 3) % 17), 8'hA5, 16'h0000, 0, 1);
    end
    add_step(0, 0, 0, 1, 3'd6, 5'd16, 8'hA5, 16'h0000, 0, 1);
    add_step(0, 0, 0, 1, 3'd2, 5'd17, 8'hA5, 16'h0000, 0, 1);
    add_step(0, 0, 0, 1, 3'd5, 5'd31, 8'hA5, 16'h0000, 0, 1);
    for (int i = 0; i < 16; i++) add_step(0, 0, 0, 0, 0, 0, 8'hA5, 16'h0000, 1, 1);
  endtask

  // One rising edge of the model, using the inputs seen at that edge
  task automatic model_edge();
    int src;
    if (reset_i) begin
      exp_pad = '0;
      exp_oe = '0;
      exp_pin = '0;
      exp_straps = '0;
      exp_valid = 1'b0;
      m_strap_cnt = 0;
      foreach (m_out_sel[k]) m_out_sel[k] = '0;
      foreach (m_in_sel[i]) m_in_sel[i] = '0;
    end else begin
      foreach (m_out_sel[k]) begin
        src = int'(m_out_sel[k]) - 1;
        exp_oe[k] = (src >= 0);
        exp_pad[k] = (src >= 0) ? periph_out_i[src] : 1'b0;
      end
      foreach (m_in_sel[i]) begin
        src = int'(m_in_sel[i]) - 1;
        exp_pin[i] = (src >= 0) ? m_sync2[src] : 1'b0;
      end
      if (!exp_valid) begin
        m_strap_cnt++;
        if (m_strap_cnt == chip_io_pkg::StrapDelay) begin
          exp_straps = m_sync2[15:13];
          exp_valid = 1'b1;
        end
      end
      if (out_sel_we_i && out_sel_i <= 4'd8) m_out_sel[out_sel_pad_i] = out_sel_i;
      if (in_sel_we_i && in_sel_i <= 5'd16) m_in_sel[in_sel_periph_i] = in_sel_i;
    end
    m_sync2 = m_sync1;  // Synchronizer runs through reset
    m_sync1 = pad_i;
  endtask

  task automatic drive_step(input step_t s);
    out_sel_we_i    = s.out_we;
    out_sel_pad_i   = s.out_pad;
    out_sel_i       = s.out_sel;
    in_sel_we_i     = s.in_we;
    in_sel_periph_i = s.in_per;
    in_sel_i        = s.in_sel;
    periph_out_i    = s.rnd_out ? chip_io_pkg::periph_out_t'($random(seed)) : s.periph_out;
    pad_i           = s.rnd_pad ? chip_io_pkg::mio_t'($random(seed)) : s.pad;
  endtask

  task automatic check_outputs();
    checks++;
    assert (pad_oe_o === exp_oe && pad_o === exp_pad) else begin
      $display("FAILED at %0t ns: pad_oe_o %h pad_o %h, expected %h %h",
               $time, pad_oe_o, pad_o, exp_oe, exp_pad);
      errors++;
    end
    assert (periph_in_o === exp_pin) else begin
      $display("FAILED at %0t ns: periph_in_o %h, expected %h", $time, periph_in_o, exp_pin);
      errors++;
    end
    assert (strap_valid_o === exp_valid && straps_o === exp_straps) else begin
      $display("FAILED at %0t ns: straps %b valid %b, expected %b %b",
               $time, straps_o, strap_valid_o, exp_straps, exp_valid);
      errors++;
    end
  endtask

  initial begin : watchdog
    int limit;
    wait (table_built);
    limit = (tbl.size() + 2 + 20) * 4;  // Reset cycles plus margin
    #(limit);
    $display("Timeout: the run did not finish within %0d ns", limit);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    clk_i = 1'b0;
    reset_i = 1'b1;
    drive_step('{default: '0});
    pad_i = 16'hA000;
    build_table();
    table_built = 1'b1;
    for (int r = 0; r < 2; r++) begin
      @(posedge clk_i);
      model_edge();
      #1;
      if (r == 1) reset_i = 1'b0;
      @(negedge clk_i);
      check_outputs();
    end
    foreach (tbl[i]) begin
      @(posedge clk_i);
      model_edge();
      #1 drive_step(tbl[i]);
      @(negedge clk_i);
      if (tbl[i].chk) check_outputs();
    end
    @(posedge clk_i);
    model_edge();
    @(negedge clk_i);
    check_outputs();
    // Straps were 101 at capture
    assert (straps_o === 3'b101) else begin
      $display("FAILED at %0t ns: straps_o %b, expected 101", $time, straps_o);
      errors++;
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: vlog.f
design/chip_io_pkg.sv
design/mio_pad.sv
design/mio_out_mux.sv
design/mio_in_router.sv
design/chip_io_top.sv
verification/tb_chip_io.sv

// File: Makefile
# Verilator build for the chip I/O block and its testbench

SIM      = verilator
VFLAGS   = --binary --timing --assert -Wno-fatal
TOP      = tb_chip_io
FILELIST = vlog.f
OBJ_DIR  = obj_dir
PASS_MSG = STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Fails unless the pass message shows up in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
